// ==== logic/mem_cache_pkg.sv ====
`default_nettype none

package mem_cache_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    localparam int LINE_BYTES = 16;               // Bytes per cache line
    localparam int APP_ADDR_W = 28;               // Controller address width
    localparam int LINE_W     = LINE_BYTES * 8;   // One line in bits

    typedef logic [LINE_W-1:0]     line_data_t;   // Full line, one app beat
    typedef logic [APP_ADDR_W-1:0] line_addr_t;   // Line address in 16-bit words

    ////////////////////
    // Host request
    ////////////////////

    typedef struct packed {
        logic [31:0] addr;    // Byte address of low lane
        logic        lo;      // Low byte wanted
        logic        hi;      // High byte wanted, sits at addr + 1
        logic        we;      // Write when set
        logic [15:0] wdata;   // High lane in [15:8]
    } host_req_t;

    ////////////////////
    // Encodings
    ////////////////////

    // Application port command codes
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    typedef enum logic [3:0] {
        ST_START,         // Wait for calibration
        ST_IDLE,          // Accept a host strobe
        ST_LOOKUP,        // Tag compare on both lanes
        ST_EVICT_CHECK,   // Decide on write-back
        ST_WRITEBACK,     // Dirty victim going out
        ST_FILL,          // Line coming in
        ST_RETURN         // Ready pulse
    } cache_state_e;

    // Everything driven toward the memory controller
    typedef struct packed {
        line_addr_t addr;
        app_cmd_e   cmd;
        logic       en;          // Command strobe
        line_data_t wdf_data;
        logic       wdf_wren;    // Write data strobe
    } app_port_t;

    // Byte address to controller line address
    // Controller counts 16-bit words, 8 words per line
    function automatic line_addr_t line_of(input logic [31:0] byte_addr);
        return {byte_addr[28:4], 3'b000};
    endfunction

endpackage

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import mem_cache_pkg::*;
#(
    parameter int CACHE_LINES = 4,
    localparam int PTR_W = $clog2(CACHE_LINES)
) (
    input  wire               ui_clk,
    input  wire               rst_n,
    input  wire               init_calib_complete,
    // Host side
    input  wire               cs,
    input  wire host_req_t    host_req,
    output logic [15:0]       rdata,
    output logic              busy,
    output logic              ready,
    // Line store
    output logic [31:0]       lo_addr,
    output logic [31:0]       hi_addr,
    output logic              wr_lo,
    output logic              wr_hi,
    output logic [15:0]       wr_data,
    output logic              fill_en,
    output logic [PTR_W-1:0]  victim_ptr,
    input  wire               lo_hit,
    input  wire               hi_hit,
    input  wire [7:0]         lo_byte,
    input  wire [7:0]         hi_byte,
    input  wire               victim_valid,
    input  wire               victim_dirty,
    // Command sequencer
    output logic              fetch_start,
    output logic              flush_start,
    output line_addr_t        miss_addr,
    input  wire               op_done
);

    cache_state_e state;
    host_req_t    req;            // Captured request
    logic         take_req;       // Strobe sampled this cycle
    logic         all_hit;        // Every requested lane present
    logic         lo_miss;
    logic         need_flush;     // Victim must go out first

    assign take_req   = (state == ST_IDLE) && cs && !busy;
    assign lo_miss    = req.lo && !lo_hit;
    assign all_hit    = !lo_miss && (!req.hi || hi_hit);
    assign need_flush = victim_valid && victim_dirty;

    // Lane addresses, high byte may cross into next line
    assign lo_addr = req.addr;
    assign hi_addr = req.addr + 32'd1;
    assign wr_data = req.wdata;

    // Byte writes only once both lanes are resident
    assign wr_lo = (state == ST_LOOKUP) && all_hit && req.we && req.lo;
    assign wr_hi = (state == ST_LOOKUP) && all_hit && req.we && req.hi;

    assign fill_en     = (state == ST_FILL) && op_done;   // Read beat lands
    assign flush_start = (state == ST_EVICT_CHECK) && need_flush;
    assign fetch_start = ((state == ST_EVICT_CHECK) && !need_flush)
                       || ((state == ST_WRITEBACK) && op_done);   // Fetch right after flush

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            state      <= ST_START;
            busy       <= 1'b1;               // Not open until calibrated
            ready      <= 1'b0;
            victim_ptr <= '0;
        end else begin
            ready <= 1'b0;                    // Single-cycle pulse
            case (state)
                ST_START: begin
                    busy <= 1'b1;
                    if (init_calib_complete) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    busy <= 1'b0;             // Drops the cycle after ready
                    if (take_req) begin
                        busy  <= 1'b1;
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= all_hit ? ST_RETURN : ST_EVICT_CHECK;
                end
                ST_EVICT_CHECK: begin
                    state <= need_flush ? ST_WRITEBACK : ST_FILL;
                end
                ST_WRITEBACK: begin
                    if (op_done) begin
                        state <= ST_FILL;     // Fetch issued on the same edge
                    end
                end
                ST_FILL: begin
                    if (op_done) begin
                        victim_ptr <= victim_ptr + 1'b1;   // Round robin
                        state      <= ST_LOOKUP;           // Look again with new line
                    end
                end
                ST_RETURN: begin
                    ready <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_START;
            endcase
        end
    end

    // Request, result and miss line
    always_ff @(posedge ui_clk) begin
        if (take_req) begin
            req <= host_req;
        end
        if (state == ST_LOOKUP) begin
            if (all_hit) begin
                // Unrequested lanes read zero, a write returns prior bytes
                rdata <= {req.hi ? hi_byte : 8'h00, req.lo ? lo_byte : 8'h00};
            end else begin
                // Low lane first
                miss_addr <= lo_miss ? line_of(lo_addr) : line_of(hi_addr);
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_ready_pulse : assert property (@(posedge ui_clk) disable iff (!rst_n)
        ready |=> !ready);

    a_one_start : assert property (@(posedge ui_clk) disable iff (!rst_n)
        !(fetch_start && flush_start));

endmodule

`default_nettype wire

// ==== logic/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store
    import mem_cache_pkg::*;
#(
    parameter int CACHE_LINES = 4,
    localparam int PTR_W = $clog2(CACHE_LINES)
) (
    input  wire               ui_clk,
    input  wire               rst_n,
    // Byte lookup, one port per lane
    input  wire [31:0]        lo_addr,
    input  wire [31:0]        hi_addr,
    input  wire               wr_lo,
    input  wire               wr_hi,
    input  wire [15:0]        wr_data,
    output logic              lo_hit,
    output logic              hi_hit,
    output logic [7:0]        lo_byte,
    output logic [7:0]        hi_byte,
    // Replacement
    input  wire               fill_en,
    input  wire line_data_t   fill_data,
    input  wire               flush_done,
    input  wire [PTR_W-1:0]   victim_ptr,
    input  wire line_addr_t   miss_addr,
    output logic              victim_valid,
    output logic              victim_dirty,
    output line_addr_t        victim_addr,
    output line_data_t        victim_data
);

    logic [CACHE_LINES-1:0] line_valid;
    line_addr_t             line_tag   [CACHE_LINES];
    line_data_t             line_data  [CACHE_LINES];
    logic [LINE_BYTES-1:0]  line_dirty [CACHE_LINES];   // One bit per byte

    logic [CACHE_LINES-1:0] lo_match;
    logic [CACHE_LINES-1:0] hi_match;
    logic [3:0]             lo_off;     // Byte within line
    logic [3:0]             hi_off;
    logic                   dup_line;

    assign lo_off = lo_addr[3:0];
    assign hi_off = hi_addr[3:0];

    ////////////////////
    // Lookup
    ////////////////////

    // Fully associative, both lanes at once
    always_comb begin
        lo_hit  = 1'b0;
        hi_hit  = 1'b0;
        lo_byte = 8'h00;
        hi_byte = 8'h00;
        for (int i = 0; i < CACHE_LINES; i++) begin
            lo_match[i] = line_valid[i] && (line_tag[i] == line_of(lo_addr));
            hi_match[i] = line_valid[i] && (line_tag[i] == line_of(hi_addr));
            if (lo_match[i]) begin
                lo_hit  = 1'b1;
                lo_byte = line_data[i][{lo_off, 3'b000} +: 8];
            end
            if (hi_match[i]) begin
                hi_hit  = 1'b1;
                hi_byte = line_data[i][{hi_off, 3'b000} +: 8];
            end
        end
    end

    // Victim slot view
    assign victim_valid = line_valid[victim_ptr];
    assign victim_dirty = |line_dirty[victim_ptr];
    assign victim_addr  = line_tag[victim_ptr];
    assign victim_data  = line_data[victim_ptr];

    ////////////////////
    // Updates
    ////////////////////

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            line_valid <= '0;
            for (int i = 0; i < CACHE_LINES; i++) begin
                line_dirty[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CACHE_LINES; i++) begin
                if (wr_lo && lo_match[i]) line_dirty[i][lo_off] <= 1'b1;
                if (wr_hi && hi_match[i]) line_dirty[i][hi_off] <= 1'b1;
            end
            if (fill_en || flush_done) begin
                line_dirty[victim_ptr] <= '0;     // Clean after fill or write-back
            end
            if (fill_en) begin
                line_valid[victim_ptr] <= 1'b1;
            end
        end
    end

    // Tags and data
    always_ff @(posedge ui_clk) begin
        for (int i = 0; i < CACHE_LINES; i++) begin
            if (wr_lo && lo_match[i]) line_data[i][{lo_off, 3'b000} +: 8] <= wr_data[7:0];
            if (wr_hi && hi_match[i]) line_data[i][{hi_off, 3'b000} +: 8] <= wr_data[15:8];
        end
        if (fill_en) begin
            line_tag[victim_ptr]  <= miss_addr;
            line_data[victim_ptr] <= fill_data;
        end
    end

    // Same line in two slots would make lookup ambiguous
    always_comb begin
        dup_line = 1'b0;
        for (int i = 0; i < CACHE_LINES; i++) begin
            for (int j = i + 1; j < CACHE_LINES; j++) begin
                if (line_valid[i] && line_valid[j] && (line_tag[i] == line_tag[j])) begin
                    dup_line = 1'b1;
                end
            end
        end
    end

    a_no_dup : assert property (@(posedge ui_clk) disable iff (!rst_n) !dup_line);

endmodule

`default_nettype wire

// ==== logic/app_cmd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module app_cmd_seq
    import mem_cache_pkg::*;
(
    input  wire               ui_clk,
    input  wire               rst_n,
    // From the cache controller
    input  wire               fetch_start,
    input  wire               flush_start,
    input  wire line_addr_t   miss_addr,
    input  wire line_addr_t   victim_addr,
    input  wire line_data_t   victim_data,
    output logic              op_done,      // One-cycle completion pulse
    output line_data_t        fill_data,    // Valid with op_done after a fetch
    // Controller application port
    output app_port_t         app_out,
    input  wire               app_rdy,
    input  wire               app_wdf_rdy,
    input  wire line_data_t   app_rd_data,
    input  wire               app_rd_data_valid
);

    logic       cmd_en;       // Command waiting for app_rdy
    logic       data_en;      // Write beat waiting for app_wdf_rdy
    logic       flushing;
    logic       reading;
    logic       cmd_left;     // Still pending after this edge
    logic       data_left;
    line_addr_t cmd_addr;
    app_cmd_e   cmd_kind;
    line_data_t wr_line;

    assign cmd_left  = cmd_en && !app_rdy;
    assign data_left = data_en && !app_wdf_rdy;

    assign app_out = '{addr: cmd_addr, cmd: cmd_kind, en: cmd_en,
                       wdf_data: wr_line, wdf_wren: data_en};

    always_ff @(posedge ui_clk) begin
        if (!rst_n) begin
            cmd_en   <= 1'b0;
            data_en  <= 1'b0;
            flushing <= 1'b0;
            reading  <= 1'b0;
            op_done  <= 1'b0;
        end else begin
            op_done <= 1'b0;
            cmd_en  <= cmd_left;                  // Drop each strobe once taken
            data_en <= data_left;
            if (flushing && !cmd_left && !data_left) begin
                flushing <= 1'b0;                 // Command and data both gone
                op_done  <= 1'b1;
            end
            if (reading && app_rd_data_valid) begin
                reading <= 1'b0;                  // Single beat is the whole line
                op_done <= 1'b1;
            end
            if (flush_start) begin
                cmd_en   <= 1'b1;
                data_en  <= 1'b1;
                flushing <= 1'b1;
            end
            if (fetch_start) begin
                cmd_en  <= 1'b1;
                reading <= 1'b1;
            end
        end
    end

    // Address, command and line payload
    always_ff @(posedge ui_clk) begin
        if (flush_start) begin
            cmd_addr <= victim_addr;
            cmd_kind <= APP_CMD_WRITE;
            wr_line  <= victim_data;
        end
        if (fetch_start) begin
            cmd_addr <= miss_addr;
            cmd_kind <= APP_CMD_READ;
        end
        if (reading && app_rd_data_valid) fill_data <= app_rd_data;
    end

    a_en_hold : assert property (@(posedge ui_clk) disable iff (!rst_n)
        cmd_en && !app_rdy |=> cmd_en);

    // Controller only starts an operation once the previous one is done
    a_start_idle : assert property (@(posedge ui_clk) disable iff (!rst_n)
        (fetch_start || flush_start) |-> !(flushing || reading));

endmodule

`default_nettype wire

// ==== logic/mem_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_cache_top
    import mem_cache_pkg::*;
#(
    parameter int CACHE_LINES = 4,                 // Power of two, 2 or more
    localparam int PTR_W = $clog2(CACHE_LINES)
) (
    input  wire               ui_clk,
    input  wire               rst_n,
    input  wire               init_calib_complete,
    // Host side
    input  wire               cs,                  // One-cycle request strobe
    input  wire host_req_t    host_req,
    output logic [15:0]       rdata,
    output logic              busy,
    output logic              ready,
    // Controller application port
    output app_port_t         app_out,
    input  wire               app_rdy,
    input  wire               app_wdf_rdy,
    input  wire line_data_t   app_rd_data,
    input  wire               app_rd_data_valid
);

    ////////////////////
    // Internal nets
    ////////////////////

    logic [31:0]      lo_addr;        // Byte address per lane
    logic [31:0]      hi_addr;
    logic             wr_lo;
    logic             wr_hi;
    logic [15:0]      wr_data;
    logic             fill_en;
    logic [PTR_W-1:0] victim_ptr;     // Round-robin slot
    logic             fetch_start;
    logic             flush_start;
    line_addr_t       miss_addr;
    logic             lo_hit;
    logic             hi_hit;
    logic [7:0]       lo_byte;
    logic [7:0]       hi_byte;
    logic             victim_valid;
    logic             victim_dirty;
    line_addr_t       victim_addr;
    line_data_t       victim_data;
    logic             op_done;        // Also ends the victim's dirty state
    line_data_t       fill_data;

    cache_ctrl #(.CACHE_LINES(CACHE_LINES)) u_ctrl (.*);

    line_store #(.CACHE_LINES(CACHE_LINES)) u_store (
        .*,
        .flush_done (op_done)         // Write-back done clears the dirty mask
    );

    app_cmd_seq u_seq (.*);

endmodule

`default_nettype wire

// ==== test/ddr_app_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_app_model
    import mem_cache_pkg::*;
(
    input  wire             ui_clk,
    input  wire             rst_n,
    input  wire app_port_t  app_in,
    output logic            app_rdy,
    output logic            app_wdf_rdy,
    output line_data_t      app_rd_data,
    output logic            app_rd_data_valid,
    output logic            init_calib_complete
);

    line_data_t mem [256];        // One entry per cache line
    logic [7:0] rd_line;
    logic [3:0] rd_wait;          // Cycles left to the read beat
    logic [7:0] wr_line;
    line_data_t wr_buf;
    logic       wr_cmd_seen;      // Write command taken
    logic       wr_data_seen;     // Write beat taken
    logic [4:0] calib_cnt;

    // Every address bit feeds the preset byte
    function automatic logic [7:0] preset_byte(input logic [11:0] a);
        return a[7:0] ^ {a[3:0], a[11:8]} ^ 8'h3c;
    endfunction

    initial begin
        app_rdy             = 1'b0;
        app_wdf_rdy         = 1'b0;
        app_rd_data         = '0;
        app_rd_data_valid   = 1'b0;
        init_calib_complete = 1'b0;
        for (int i = 0; i < 256; i++) begin
            for (int j = 0; j < LINE_BYTES; j++) begin
                mem[i][j*8 +: 8] = preset_byte({i[7:0], j[3:0]});
            end
        end
    end

    always @(posedge ui_clk) begin
        if (!rst_n) begin
            app_rdy             <= 1'b0;
            app_wdf_rdy         <= 1'b0;
            app_rd_data_valid   <= 1'b0;
            init_calib_complete <= 1'b0;
            calib_cnt           <= '0;
            rd_wait             <= '0;
            wr_cmd_seen         <= 1'b0;
            wr_data_seen        <= 1'b0;
        end else begin
            app_rdy           <= ($urandom % 4) != 0;   // Stalls about one cycle in four
            app_wdf_rdy       <= ($urandom % 4) != 0;
            app_rd_data_valid <= 1'b0;
            if (calib_cnt != 5'd20) calib_cnt <= calib_cnt + 5'd1;
            else init_calib_complete <= 1'b1;
            if (rd_wait != 4'd0) begin
                rd_wait <= rd_wait - 4'd1;
                if (rd_wait == 4'd1) begin
                    app_rd_data       <= mem[rd_line];  // Single beat, whole line
                    app_rd_data_valid <= 1'b1;
                end
            end
            if (wr_cmd_seen && wr_data_seen) begin
                mem[wr_line] <= wr_buf;
                wr_cmd_seen  <= 1'b0;
                wr_data_seen <= 1'b0;
            end
            if (app_in.en && app_rdy) begin
                if (app_in.cmd == APP_CMD_READ) begin
                    rd_line <= app_in.addr[10:3];
                    rd_wait <= 4'(2 + ($urandom % 11));  // 2 to 12 cycles
                end else begin
                    wr_line     <= app_in.addr[10:3];
                    wr_cmd_seen <= 1'b1;
                end
            end
            if (app_in.wdf_wren && app_wdf_rdy) begin
                wr_buf       <= app_in.wdf_data;
                wr_data_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_mem_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_cache
    import mem_cache_pkg::*;
;

    localparam int CACHE_LINES    = 4;
    localparam int DIRECTED_OPS   = 32;
    localparam int RAND_OPS       = 200;
    localparam int TIMEOUT_CYCLES = 300 * (DIRECTED_OPS + RAND_OPS);

    logic        ui_clk = 1'b0;
    logic        rst_n  = 1'b0;
    logic        cs     = 1'b0;
    host_req_t   host_req = '0;
    logic [15:0] rdata;
    logic        busy;
    logic        ready;
    app_port_t   app_out;
    logic        app_rdy;
    logic        app_wdf_rdy;
    line_data_t  app_rd_data;
    logic        app_rd_data_valid;
    logic        init_calib_complete;

    logic [7:0]  shadow [4096];     // Host view of memory
    logic [15:0] exp_q [$];         // Expected rdata per request
    logic        read_q [$];        // Only reads are compared
    logic [15:0] exp_val;
    logic        exp_read;
    int          cycles = 0;

    always #5 ui_clk = ~ui_clk;

    mem_cache_top #(.CACHE_LINES(CACHE_LINES)) uut (
        .ui_clk, .rst_n, .init_calib_complete, .cs, .host_req,
        .rdata, .busy, .ready, .app_out, .app_rdy, .app_wdf_rdy,
        .app_rd_data, .app_rd_data_valid
    );

    ddr_app_model u_ddr (
        .ui_clk, .rst_n, .app_in(app_out), .app_rdy, .app_wdf_rdy,
        .app_rd_data, .app_rd_data_valid, .init_calib_complete
    );

    ////////////////////
    // Reference and compare
    ////////////////////

    // Unrequested lanes read as zero
    function automatic logic [15:0] expect_bytes(input logic [31:0] addr,
                                                 input logic lo, input logic hi);
        logic [7:0] lo_b;
        logic [7:0] hi_b;
        lo_b = lo ? shadow[addr[11:0]] : 8'h00;
        hi_b = hi ? shadow[addr[11:0] + 12'd1] : 8'h00;   // High byte at addr + 1
        return {hi_b, lo_b};
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want,
                            input string what);
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, want);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // One request, then wait for its ready pulse
    task automatic host_op(input logic [31:0] addr, input logic lo, input logic hi,
                           input logic we, input logic [15:0] wdata);
        @(posedge ui_clk);
        while (busy) @(posedge ui_clk);
        cs       <= 1'b1;
        host_req <= '{addr: addr, lo: lo, hi: hi, we: we, wdata: wdata};
        exp_q.push_back(expect_bytes(addr, lo, hi));
        read_q.push_back(!we);
        if (we && lo) shadow[addr[11:0]] = wdata[7:0];
        if (we && hi) shadow[addr[11:0] + 12'd1] = wdata[15:8];
        @(posedge ui_clk);
        cs <= 1'b0;                                     // Strobe lasts one cycle
        do @(posedge ui_clk); while (!ready);
    endtask

    always @(posedge ui_clk) begin
        if (rst_n && ready) begin
            if (exp_q.size() == 0) begin
                $display("Ready pulse arrived with no request outstanding");
                $display("Simulation failed");
                $fatal(1);
            end else begin
                exp_val  = exp_q.pop_front();
                exp_read = read_q.pop_front();
                if (exp_read) check_eq(32'(rdata), 32'(exp_val), "read data");
            end
        end
    end

    always @(posedge ui_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [31:0] addr;
        logic [31:0] bits;
        void'($urandom(32'h86dc));
        repeat (8) @(posedge ui_clk);
        rst_n <= 1'b1;
        for (int a = 0; a < 4096; a++) shadow[a] = u_ddr.mem[a / 16][(a % 16) * 8 +: 8];
        // Strobe held through calibration must be ignored
        cs       <= 1'b1;
        host_req <= '{addr: 32'h040, lo: 1'b1, hi: 1'b1, we: 1'b0, wdata: 16'h0000};
        repeat (18) begin                               // Calibration still pending
            @(posedge ui_clk);
            check_eq(32'(busy), 32'd1, "busy before calibration");
            check_eq(32'(ready), 32'd0, "ready before calibration");
        end
        cs <= 1'b0;
        host_op(32'h040, 1'b1, 1'b1, 1'b1, 16'hbeef);
        host_op(32'h040, 1'b1, 1'b1, 1'b0, 16'h0000);
        // Single lanes leave neighbour bytes alone
        host_op(32'h123, 1'b1, 1'b1, 1'b1, 16'h2211);
        host_op(32'h123, 1'b1, 1'b0, 1'b1, 16'hee33);
        host_op(32'h123, 1'b1, 1'b1, 1'b0, 16'h0000);
        host_op(32'h123, 1'b0, 1'b1, 1'b1, 16'h44ff);
        host_op(32'h123, 1'b1, 1'b0, 1'b0, 16'h0000);
        host_op(32'h123, 1'b0, 1'b1, 1'b0, 16'h0000);
        host_op(32'h125, 1'b1, 1'b0, 1'b0, 16'h0000);
        host_op(32'h20f, 1'b1, 1'b1, 1'b1, 16'hc3a5);   // Pair crosses a line boundary
        host_op(32'h20f, 1'b1, 1'b1, 1'b0, 16'h0000);
        host_op(32'h210, 1'b1, 1'b0, 1'b0, 16'h0000);
        // Twice the cache size in dirty lines
        for (int k = 0; k < 2 * CACHE_LINES; k++) host_op(32'h405 + 32'(k * 16), 1'b1, 1'b1,
                                                          1'b1, 16'($urandom));
        for (int k = 0; k < 2 * CACHE_LINES; k++) host_op(32'h405 + 32'(k * 16), 1'b1, 1'b1,
                                                          1'b0, 16'h0000);
        for (int k = 0; k < CACHE_LINES; k++) host_op(32'h800 + 32'(k * 16), 1'b1, 1'b0,
                                                      1'b0, 16'h0000);
        for (int k = 0; k < 2 * CACHE_LINES; k++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                check_eq(32'(u_ddr.mem[8'h40 + k][b * 8 +: 8]),
                         32'(shadow[12'h400 + 12'(k * 16 + b)]), "evicted byte in memory");
            end
        end
        repeat (RAND_OPS) begin
            addr = 32'h100 + ($urandom % 32'd191);      // Twelve lines with the pair inside
            bits = $urandom;
            host_op(addr, bits[0], bits[1], bits[2], bits[31:16]);
        end
        repeat (2) @(posedge ui_clk);
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/mem_cache_pkg.sv
logic/cache_ctrl.sv
logic/line_store.sv
logic/app_cmd_seq.sv
logic/mem_cache_top.sv
test/ddr_app_model.sv
test/tb_mem_cache.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_mem_cache
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation passed" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
